// File: include/pc_cfg.svh
// Shared widths, fetch timing and flag bit positions, included by the PC subsystem and its testbench
`ifndef PC_CFG_SVH
`define PC_CFG_SVH

// PC and register target width
`define PC_W 16

// Branch offset width, in instruction words
`define OFS_W 9

// Memory wait cycles per fetch, 1 or more
`define FETCH_WAIT 2

// Bit positions in the flag vector
`define FLAG_Z 0
`define FLAG_V 1
`define FLAG_N 2

`endif

// File: source/pc_pkg.sv
// Enumerated types for branch decode, flag writes and fetch sequencing, imported by the PC blocks
package pc_pkg;

	// Branch condition, encoding fixed by the ISA
	typedef enum logic [2:0] {
		cond_ne     = 3'b000,	// Z == 0
		cond_eq     = 3'b001,	// Z == 1
		cond_gt     = 3'b010,	// Z == N == 0
		cond_lt     = 3'b011,	// N == 1
		cond_ge     = 3'b100,	// Z == 1 or Z == N == 0
		cond_le     = 3'b101,	// N == 1 or Z == 1
		cond_ovf    = 3'b110,	// V == 1
		cond_always = 3'b111	// Unconditional
	} cond_t;

	// Branch instruction class
	typedef enum logic [1:0] {
		br_b   = 2'b00,	// PC-relative
		br_br  = 2'b01,	// Register target
		br_pcs = 2'b10,	// Save PC+2 to link
		br_hlt = 2'b11	// Halt, PC holds
	} br_type_t;

	// Which flags an execute result may update
	typedef enum logic [1:0] {
		flag_none  = 2'b00,	// No flag touched
		flag_arith = 2'b01,	// Z, V and N
		flag_logic = 2'b10,	// Z only
		flag_shift = 2'b11	// Z and N
	} flag_sel_t;

	// Fetch sequencer states
	typedef enum logic [1:0] {
		st_reset = 2'b00,	// Post-reset settle
		st_req   = 2'b01,	// Issue fetch request
		st_wait  = 2'b10,	// Memory wait states
		st_halt  = 2'b11	// Stopped until reset
	} fetch_state_t;

endpackage

// File: source/branch_if.sv
// Decoded branch fields passed from the top level to the next-PC logic and fetch sequencer
`timescale 1ns/1ps
`include "pc_cfg.svh"

interface branch_if;

	pc_pkg::cond_t     c;	// Branch condition
	logic [`OFS_W-1:0] offset;	// Word offset, signed
	logic [`PC_W-1:0]  target;	// Register value for BR
	logic              branch;	// Branch instruction
	pc_pkg::br_type_t  branch_type;	// B / BR / PCS / HLT
	logic              pcs;	// Link save
	logic              hlt;	// Halt request

	// Decoder side, driven at the top level
	modport src (
		output c, offset, target, branch, branch_type, pcs, hlt
	);

	// Next-PC logic consumes the whole bundle
	modport ctrl (
		input c, offset, target, branch, branch_type, pcs, hlt
	);

	// Sequencing side only needs halt and link control
	modport seq (
		input hlt, pcs
	);

endinterface

// File: source/pc_control.sv
// Combinational next-PC logic, evaluates the branch condition on Z/V/N and picks one of four sources
`timescale 1ns/1ps
`include "pc_cfg.svh"

module pc_control import pc_pkg::*; (
	branch_if.ctrl          br,	// Decoded branch fields
	input  logic [2:0]      flags,	// Registered Z/V/N
	input  logic [`PC_W-1:0] pc_in,	// Current PC
	output logic [`PC_W-1:0] pc_out,	// Next PC
	output logic [`PC_W-1:0] pc_plus2	// Sequential PC, also the link value
);

	localparam int PC_W = `PC_W;
	localparam int OFS_W = `OFS_W;
	localparam logic [PC_W-1:0] PC_STEP = 2;	// Instructions are 2 bytes

	logic            flag_z;
	logic            flag_v;
	logic            flag_n;
	logic            taken;	// Condition satisfied
	logic [PC_W-1:0] ofs_ext;	// Sign-extended offset
	logic [PC_W-1:0] ofs_byte;	// Offset in bytes
	logic [PC_W-1:0] pc_rel;	// B target
	logic [PC_W-1:0] pc_sel;	// Per-class choice

	assign flag_z = flags[`FLAG_Z];
	assign flag_v = flags[`FLAG_V];
	assign flag_n = flags[`FLAG_N];

	// Condition table
	always_comb begin
		taken = 1'b0;
		case (br.c)
			cond_ne:     taken = ~flag_z;
			cond_eq:     taken = flag_z;
			cond_gt:     taken = ~flag_z & ~flag_n;
			cond_lt:     taken = flag_n;
			cond_ge:     taken = flag_z | (~flag_z & ~flag_n);	// Equal or greater
			cond_le:     taken = flag_n | flag_z;
			cond_ovf:    taken = flag_v;
			cond_always: taken = 1'b1;
			default:     taken = 1'b0;
		endcase
	end

	assign ofs_ext  = {{(PC_W - OFS_W){br.offset[OFS_W-1]}}, br.offset};
	assign ofs_byte = ofs_ext << 1;	// Word offset to byte offset
	assign pc_plus2 = pc_in + PC_STEP;
	assign pc_rel   = pc_plus2 + ofs_byte;	// Relative to the following instruction

	// Source by branch class
	always_comb begin
		pc_sel = pc_plus2;
		case (br.branch_type)
			br_b:   pc_sel = (br.branch && taken) ? pc_rel : pc_plus2;
			br_br:  pc_sel = (br.branch && taken) ? br.target : pc_plus2;
			br_pcs: pc_sel = pc_plus2;	// Link captured by the sequencer
			br_hlt: pc_sel = pc_in;	// Freeze on halt
		endcase
	end

	// Ordinary instructions always fall through
	assign pc_out = (br.branch || br.hlt || br.pcs) ? pc_sel : pc_plus2;

endmodule

// File: source/flag_unit.sv
// Z/V/N flag register written by the execute stage, each result class updates only its own flags
`timescale 1ns/1ps
`include "pc_cfg.svh"

module flag_unit import pc_pkg::*; (
	input  logic      clk,
	input  logic      reset,	// Sync, active high
	input  logic      flag_wr,	// Write strobe
	input  flag_sel_t flag_sel,	// Result class
	input  logic [2:0] flag_in,	// New Z/V/N
	output logic [2:0] flags	// Registered Z/V/N
);

	logic [2:0] wr_mask;	// Bits this class may touch

	// Per-class write enables
	always_comb begin
		wr_mask = 3'b000;
		case (flag_sel)
			flag_none: wr_mask = 3'b000;
			flag_arith: begin
				wr_mask[`FLAG_Z] = 1'b1;
				wr_mask[`FLAG_V] = 1'b1;
				wr_mask[`FLAG_N] = 1'b1;
			end
			flag_logic: wr_mask[`FLAG_Z] = 1'b1;	// Logic ops only set zero
			flag_shift: begin
				wr_mask[`FLAG_Z] = 1'b1;
				wr_mask[`FLAG_N] = 1'b1;	// Shifts cannot overflow
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			flags <= 3'b000;
		end else if (flag_wr) begin
			flags <= (flags & ~wr_mask) | (flag_in & wr_mask);	// Merge masked bits
		end
	end

endmodule

// File: source/wait_timer.sv
// Down-counter timing memory wait states for each fetch, reports when the wait has elapsed
`timescale 1ns/1ps
`include "pc_cfg.svh"

module wait_timer (
	input  logic clk,
	input  logic reset,	// Sync, active high
	input  logic load,	// Restart at FETCH_WAIT
	output logic expired	// Count reached zero
);

	localparam int CNT_W = $clog2(`FETCH_WAIT + 1);
	localparam logic [CNT_W-1:0] CNT_INIT = CNT_W'(`FETCH_WAIT);

	logic [CNT_W-1:0] count;	// Remaining wait cycles

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
		end else if (load) begin
			count <= CNT_INIT;
		end else if (count != '0) begin
			count <= count - 1'b1;	// Holds at zero
		end
	end

	assign expired = (count == '0);

endmodule

// File: source/fetch_fsm.sv
// Fetch sequencer that issues fetch requests, waits out memory latency and retires instructions
`timescale 1ns/1ps
`include "pc_cfg.svh"

module fetch_fsm import pc_pkg::*; (
	input  logic    clk,
	input  logic    reset,	// Sync, active high
	branch_if.seq   br,	// Halt and link fields
	input  logic    instr_valid,	// Decoder has an instruction
	input  logic    expired,	// Wait states done
	output logic    fetch_req,	// One-cycle fetch pulse
	output logic    load,	// Start the wait timer
	output logic    advance,	// Retire and update PC
	output logic    halted	// Stopped on HLT
);

	fetch_state_t state;
	fetch_state_t state_nx;
	logic         rst_seen;	// One cycle out of reset

	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= st_reset;
			rst_seen <= 1'b0;
		end else begin
			state    <= state_nx;
			rst_seen <= 1'b1;
		end
	end

	// Next state
	always_comb begin
		state_nx = state;
		case (state)
			st_reset: begin
				if (rst_seen) begin
					state_nx = st_req;	// Settle one cycle after release
				end
			end
			st_req: state_nx = st_wait;
			st_wait: begin
				if (advance) begin
					state_nx = br.hlt ? st_halt : st_req;
				end
			end
			st_halt: state_nx = st_halt;	// Only reset leaves
		endcase
	end

	assign fetch_req = (state == st_req);
	assign load      = fetch_req;	// Timer starts with the request
	// Stalls here while the decoder is not ready
	assign advance   = (state == st_wait) && expired && instr_valid;
	assign halted    = (state == st_halt);

endmodule

// File: source/pc_sequencer.sv
// Architectural PC, PCS link register and retired-instruction counter, all updated on advance
`timescale 1ns/1ps
`include "pc_cfg.svh"

module pc_sequencer (
	input  logic             clk,
	input  logic             reset,	// Sync, active high
	input  logic             advance,	// Instruction retires
	input  logic             pcs,	// Save link on this one
	input  logic [`PC_W-1:0] pc_next,	// From next-PC logic
	input  logic [`PC_W-1:0] pc_plus2,	// Return address
	output logic [`PC_W-1:0] pc,	// Current PC
	output logic [`PC_W-1:0] link,	// Saved return address
	output logic [15:0]      retired	// Retired count, wraps
);

	always_ff @(posedge clk) begin
		if (reset) begin
			pc      <= '0;
			link    <= '0;
			retired <= '0;
		end else if (advance) begin
			pc      <= pc_next;
			retired <= retired + 16'd1;
			if (pcs) begin
				link <= pc_plus2;	// PC+2 of the PCS itself
			end
		end
	end

endmodule

// File: source/pc_unit.sv
// Top level of the program-counter subsystem, wires next-PC logic, flags, fetch pacing and PC state
`timescale 1ns/1ps
`include "pc_cfg.svh"

module pc_unit import pc_pkg::*; (
	input  logic              clk,
	input  logic              reset,	// Sync, active high
	input  cond_t             c,	// Branch condition
	input  logic [`OFS_W-1:0] offset,	// B offset in words
	input  logic [`PC_W-1:0]  target,	// BR register value
	input  logic              branch,
	input  br_type_t          branch_type,
	input  logic              pcs,
	input  logic              hlt,
	input  logic              instr_valid,	// Decoder ready, else stall
	input  logic              flag_wr,
	input  flag_sel_t         flag_sel,
	input  logic [2:0]        flag_in,
	output logic [`PC_W-1:0]  pc,
	output logic [`PC_W-1:0]  link,
	output logic [15:0]       retired,
	output logic              fetch_req,	// Start of a fetch
	output logic              ready,	// Instruction retired
	output logic              halted
);

	branch_if bi ();

	logic [2:0]       flags;
	logic [`PC_W-1:0] pc_next;
	logic [`PC_W-1:0] pc_plus2;
	logic             expired;
	logic             load;
	logic             advance;

	// Decoded fields onto the bundle
	assign bi.c           = c;
	assign bi.offset      = offset;
	assign bi.target      = target;
	assign bi.branch      = branch;
	assign bi.branch_type = branch_type;
	assign bi.pcs         = pcs;
	assign bi.hlt         = hlt;

	pc_control ctrl_i (
		.br       (bi.ctrl),
		.flags    (flags),
		.pc_in    (pc),	// Feedback from the PC register
		.pc_out   (pc_next),
		.pc_plus2 (pc_plus2)
	);

	flag_unit flag_i (
		.clk      (clk),
		.reset    (reset),
		.flag_wr  (flag_wr),
		.flag_sel (flag_sel),
		.flag_in  (flag_in),
		.flags    (flags)
	);

	wait_timer timer_i (
		.clk     (clk),
		.reset   (reset),
		.load    (load),
		.expired (expired)
	);

	fetch_fsm fsm_i (
		.clk         (clk),
		.reset       (reset),
		.br          (bi.seq),
		.instr_valid (instr_valid),
		.expired     (expired),
		.fetch_req   (fetch_req),
		.load        (load),
		.advance     (advance),
		.halted      (halted)
	);

	pc_sequencer seq_i (
		.clk      (clk),
		.reset    (reset),
		.advance  (advance),
		.pcs      (bi.pcs),
		.pc_next  (pc_next),
		.pc_plus2 (pc_plus2),
		.pc       (pc),
		.link     (link),
		.retired  (retired)
	);

	assign ready = advance;	// Retire strobe seen by the decoder

endmodule

// File: tb/tb_clock.sv
// Testbench clock and reset source, 100 ns period with reset held for five rising edges
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;	// 100 ns period
	end

	initial begin
		reset = 1'b1;
		repeat (5) @(posedge clk);
		#1 reset = 1'b0;	// Released just after the fifth edge
	end

endmodule

// File: tb/pc_unit_tb.sv
// Table-driven testbench for the PC subsystem that checks next PC, link, retire count, pacing and halt
`timescale 1ns/1ps
`include "pc_cfg.svh"

module pc_unit_tb import pc_pkg::*; ();

	localparam int PC_W = `PC_W;

	typedef struct {
		logic              fwr;	// Flag write with this row
		flag_sel_t         fsel;
		logic [2:0]        fin;
		cond_t             c;
		logic              branch;
		br_type_t          bt;
		logic              pcs;
		logic              hlt;
		logic [`OFS_W-1:0] offset;
		logic [PC_W-1:0]   target;
		int                delay;	// Cycles instr_valid stays low
	} row_t;

	logic              clk;
	logic              reset;
	cond_t             c;
	logic [`OFS_W-1:0] offset;
	logic [PC_W-1:0]   target;
	logic              branch;
	br_type_t          branch_type;
	logic              pcs;
	logic              hlt;
	logic              instr_valid;
	logic              flag_wr;
	flag_sel_t         flag_sel;
	logic [2:0]        flag_in;
	logic [PC_W-1:0]   pc;
	logic [PC_W-1:0]   link;
	logic [15:0]       retired;
	logic              fetch_req;
	logic              ready;
	logic              halted;

	row_t            rows[$];	// Stimulus table
	int              cycle = 0;	// Rising edges so far
	int              limit = 0;	// Watchdog bound
	int              max_delay;
	int              value_errs;
	int              timing_errs;
	int              release_cyc;
	int              fetch_cyc;
	int              seed;
	logic [PC_W-1:0] m_pc;	// Reference model state
	logic [PC_W-1:0] m_link;
	logic [15:0]     m_retired;
	logic [2:0]      m_flags;

	tb_clock clk_i (.clk(clk), .reset(reset));

	pc_unit dut_i (
		.clk(clk), .reset(reset), .c(c), .offset(offset), .target(target),
		.branch(branch), .branch_type(branch_type), .pcs(pcs), .hlt(hlt),
		.instr_valid(instr_valid), .flag_wr(flag_wr), .flag_sel(flag_sel),
		.flag_in(flag_in), .pc(pc), .link(link), .retired(retired),
		.fetch_req(fetch_req), .ready(ready), .halted(halted)
	);

	always @(posedge clk) cycle <= cycle + 1;

	function automatic logic [2:0] pack_flags(input logic z, input logic v, input logic n);
		logic [2:0] f;
		f = 3'b000;
		f[`FLAG_Z] = z;
		f[`FLAG_V] = v;
		f[`FLAG_N] = n;
		return f;
	endfunction

	// Branch condition table on Z/V/N
	function automatic logic cond_holds(input cond_t cc, input logic [2:0] f);
		logic z;
		logic v;
		logic n;
		z = f[`FLAG_Z];
		v = f[`FLAG_V];
		n = f[`FLAG_N];
		case (cc)
			cond_ne: return !z;
			cond_eq: return z;
			cond_gt: return !z && !n;
			cond_lt: return n;
			cond_ge: return z || (!z && !n);
			cond_le: return n || z;
			cond_ovf: return v;
			default: return 1'b1;	// Always
		endcase
	endfunction

	task automatic add_row(input logic fwr, input flag_sel_t fsel, input logic [2:0] fin,
			input cond_t cc, input logic br, input br_type_t bt, input logic ps,
			input logic ht, input int delay);
		logic [`OFS_W-1:0] ofs;
		logic [PC_W-1:0]   tgt;
		ofs = `OFS_W'($urandom);
		if (ofs == '0) begin
			ofs = `OFS_W'(1);	// Taken and not-taken must differ
		end
		tgt = PC_W'($urandom) & ~PC_W'(1);	// Keep targets even
		rows.push_back('{fwr, fsel, fin, cc, br, bt, ps, ht, ofs, tgt, delay});
		if (delay > max_delay) begin
			max_delay = delay;
		end
	endtask

	task automatic build_table();
		logic [2:0] sets [3];
		sets[0] = pack_flags(1'b1, 1'b0, 1'b0);	// Zero
		sets[1] = pack_flags(1'b0, 1'b1, 1'b1);	// Negative with overflow
		sets[2] = pack_flags(1'b0, 1'b0, 1'b0);	// Positive
		add_row(1'b0, flag_none, 3'b000, cond_always, 1'b0, br_b, 1'b0, 1'b0, 0);
		add_row(1'b1, flag_arith, sets[1], cond_always, 1'b0, br_b, 1'b0, 1'b0, 3);
		// Each condition against all three flag sets
		for (int ci = 0; ci < 8; ci++) begin
			for (int s = 0; s < 3; s++) begin
				add_row(1'b1, flag_arith, sets[s], cond_t'(ci), 1'b1, br_b, 1'b0, 1'b0,
					((ci + s) % 5 == 4) ? 5 : 0);
			end
		end
		add_row(1'b1, flag_arith, sets[0], cond_eq, 1'b1, br_br, 1'b0, 1'b0, 0);	// BR taken
		add_row(1'b0, flag_none, 3'b000, cond_ne, 1'b1, br_br, 1'b0, 1'b0, 1);	// BR falls through
		add_row(1'b0, flag_none, 3'b000, cond_always, 1'b0, br_pcs, 1'b1, 1'b0, 2);	// PCS
		add_row(1'b1, flag_arith, pack_flags(1'b0, 1'b0, 1'b1), cond_always, 1'b0, br_b,
			1'b0, 1'b0, 0);	// Sets N
		add_row(1'b1, flag_logic, 3'b000, cond_lt, 1'b1, br_b, 1'b0, 1'b0, 0);	// N must survive
		add_row(1'b1, flag_arith, pack_flags(1'b1, 1'b1, 1'b0), cond_ovf, 1'b1, br_b,
			1'b0, 1'b0, 0);
		add_row(1'b0, flag_none, 3'b000, cond_lt, 1'b1, br_b, 1'b0, 1'b0, 0);	// N now clear
		add_row(1'b0, flag_none, 3'b000, cond_eq, 1'b1, br_b, 1'b0, 1'b0, 0);	// Z now set
		add_row(1'b1, flag_shift, pack_flags(1'b0, 1'b0, 1'b1), cond_ovf, 1'b1, br_b,
			1'b0, 1'b0, 4);	// V untouched by shift
		add_row(1'b0, flag_none, 3'b000, cond_always, 1'b0, br_hlt, 1'b0, 1'b1, 0);
	endtask

	task automatic update_model(input row_t r);
		logic [PC_W-1:0] seq_pc;
		logic [PC_W-1:0] rel;
		if (r.fwr) begin
			case (r.fsel)
				flag_arith: m_flags = r.fin;
				flag_logic: m_flags[`FLAG_Z] = r.fin[`FLAG_Z];
				flag_shift: begin
					m_flags[`FLAG_Z] = r.fin[`FLAG_Z];
					m_flags[`FLAG_N] = r.fin[`FLAG_N];
				end
				default: ;
			endcase
		end
		seq_pc = m_pc + PC_W'(2);
		rel = seq_pc + PC_W'($signed(r.offset) * 2);	// Offset counts words
		if (r.hlt) begin
			m_pc = m_pc;
		end else if (r.pcs) begin
			m_link = seq_pc;
			m_pc = seq_pc;
		end else if (r.branch && cond_holds(r.c, m_flags)) begin
			m_pc = (r.bt == br_br) ? r.target : rel;
		end else begin
			m_pc = seq_pc;
		end
		m_retired = m_retired + 16'd1;
	endtask

	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			value_errs++;
			$display("ERROR t=%0t %s expected 0x%0h got 0x%0h", $time, name, exp, act);
		end
	endtask

	// Called 1 ns after a rising edge and returns at the same point after the advance edge
	task automatic apply_row(input row_t r);
		bit seen;
		int exp_wait;
		seen = 1'b0;
		c = r.c;
		offset = r.offset;
		target = r.target;
		branch = r.branch;
		branch_type = r.bt;
		pcs = r.pcs;
		hlt = r.hlt;
		flag_wr = r.fwr;
		flag_sel = r.fsel;
		flag_in = r.fin;
		instr_valid = 1'b0;
		while (!seen) begin
			@(negedge clk);
			if (fetch_req) begin
				seen = 1'b1;
			end else begin
				@(posedge clk);
				#1 flag_wr = 1'b0;	// Single-cycle write
			end
		end
		fetch_cyc = cycle;
		for (int k = 0; k <= r.delay; k++) begin
			@(posedge clk);
			#1 flag_wr = 1'b0;
		end
		instr_valid = 1'b1;
		@(negedge clk);
		while (!ready) @(negedge clk);
		exp_wait = (r.delay > `FETCH_WAIT) ? r.delay + 1 : `FETCH_WAIT + 1;
		if (cycle - fetch_cyc != exp_wait) begin
			timing_errs++;
			$display("At %0t ready came %0d cycles after fetch_req instead of %0d",
				$time, cycle - fetch_cyc, exp_wait);
		end
		update_model(r);
		@(posedge clk);
		#1;
		compare("pc", m_pc, pc);
		compare("link", m_link, link);
		compare("retired", m_retired, retired);
		compare("halted", r.hlt, halted);
	endtask

	initial begin
		wait (limit > 0);
		wait (cycle > limit);
		$display("Run stopped after %0d cycles without finishing the table", limit);
		$display("Errors: %0d value, %0d timing", value_errs, timing_errs);
		$display("Test failed");
		$finish;
	end

	initial begin
		seed = $urandom(32'h363);
		value_errs = 0;
		timing_errs = 0;
		max_delay = 0;
		c = cond_ne;
		offset = '0;
		target = '0;
		branch = 1'b0;
		branch_type = br_b;
		pcs = 1'b0;
		hlt = 1'b0;
		instr_valid = 1'b0;
		flag_wr = 1'b0;
		flag_sel = flag_none;
		flag_in = 3'b000;
		m_pc = '0;
		m_link = '0;
		m_retired = '0;
		m_flags = 3'b000;
		build_table();
		limit = rows.size() * (`FETCH_WAIT + 2 + max_delay) + 50;
		@(negedge reset);
		release_cyc = cycle;
		@(negedge clk);
		compare("pc", 0, pc);
		compare("link", 0, link);
		compare("retired", 0, retired);
		compare("halted", 0, halted);
		compare("fetch_req", 0, fetch_req);
		@(posedge clk);
		#1;
		foreach (rows[i]) begin
			apply_row(rows[i]);
			if (i == 0 && fetch_cyc - release_cyc != 2) begin
				timing_errs++;
				$display("First fetch_req came %0d cycles after reset release instead of 2",
					fetch_cyc - release_cyc);
			end
		end
		repeat (10) begin	// PC and count frozen while halted
			@(negedge clk);
			if (fetch_req) begin
				timing_errs++;
				$display("A fetch_req appeared at %0t while halted", $time);
			end
			compare("pc", m_pc, pc);
			compare("retired", m_retired, retired);
			compare("halted", 1, halted);
		end
		$display("Errors: %0d value, %0d timing", value_errs, timing_errs);
		if (value_errs + timing_errs == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: vlog.f
+incdir+include
source/pc_pkg.sv
source/branch_if.sv
source/pc_control.sv
source/flag_unit.sv
source/wait_timer.sv
source/fetch_fsm.sv
source/pc_sequencer.sv
source/pc_unit.sv
tb/tb_clock.sv
tb/pc_unit_tb.sv

// File: run.sh
#!/bin/sh
# Build the PC subsystem testbench with Verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f vlog.f --top-module pc_unit_tb -o pc_unit_sim \
	&& ./obj_dir/pc_unit_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "^Test completed successfully$" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
